/* rtl/armCtrl_params.svh */
`ifndef ARMCTRL_PARAMS_SVH
`define ARMCTRL_PARAMS_SVH

// ======================================================================
// Widths
// ======================================================================
`define ARM_INSTR_W     32        // Instruction word
`define ARM_REG_W       4         // Register index
`define ARM_FLAGS_W     4         // NZCV
`define ARM_MASK_W      4         // Byte lanes per word
`define ARM_ADDR_LOW_W  2         // Address bits that pick a lane

// Instruction fields
`define ARM_COND_MSB    31
`define ARM_COND_LSB    28
`define ARM_CLASS_MSB   27        // Top of the 3-bit class field
`define ARM_CLASS_LSB   25
`define ARM_I_BIT       25        // Immediate / register form
`define ARM_OPC_MSB     24
`define ARM_OPC_LSB     21
`define ARM_B_BIT       22        // Byte access for LDR/STR
`define ARM_S_BIT       20        // Set flags on data-processing
`define ARM_L_BIT       20        // Load when set, store when clear
`define ARM_RD_MSB      15
`define ARM_RD_LSB      12
`define ARM_REGSHIFT_BIT 4        // Set in a register-form LDR/STR means undefined

// NZCV bit positions
`define ARM_N_BIT       3
`define ARM_Z_BIT       2
`define ARM_C_BIT       1
`define ARM_V_BIT       0

`endif

/* rtl/armCtrlPkg.sv */
`include "armCtrl_params.svh"

package armCtrlPkg;

  // Condition field, ARM order
  typedef enum logic [3:0] {
    condEQ, condNE, condCS, condCC,
    condMI, condPL, condVS, condVC,
    condHI, condLS, condGE, condLT,
    condGT, condLE, condAL, condNV
  } condCode_t;

  // Data-processing opcodes, bits 24:21
  typedef enum logic [3:0] {
    aluAnd, aluEor, aluSub, aluRsb,
    aluAdd, aluAdc, aluSbc, aluRsc,
    aluTst, aluTeq, aluCmp, aluCmn,
    aluOrr, aluMov, aluBic, aluMvn
  } aluOp_t;

  typedef enum logic [2:0] {
    opDataProc, opLoad, opStore, opBranch, opUndef
  } opClass_t;

  // One instruction's control as it walks down the pipe
  typedef struct packed {
    opClass_t                    op;
    aluOp_t                      aluOp;
    condCode_t                   cond;
    logic                        regWrite;
    logic                        memWrite;
    logic                        memToReg;    // Load result goes to Rd
    logic                        setFlags;    // S bit
    logic                        byteAccess;
    logic [`ARM_REG_W-1:0]       rd;
    logic [`ARM_FLAGS_W-1:0]     aluFlags;    // From datapath, with the instruction
    logic [`ARM_ADDR_LOW_W-1:0]  addrLow;
    logic [`ARM_FLAGS_W-1:0]     flagsNext;   // Filled in execute
    logic                        condPass;    // Filled in execute
    logic [`ARM_MASK_W-1:0]      byteMask;    // Filled in memory
  } ctrlWord_t;

endpackage

/* rtl/stageIf.sv */
`timescale 1ns/1ps

// Valid/ready link between two pipeline slots
interface stageIf;
  import armCtrlPkg::*;

  logic      valid;   // Source has an item
  logic      ready;   // Sink can take it
  ctrlWord_t ctrl;
  logic      xfer;    // Item moves on this clock

  assign xfer = valid && ready;

  // Upstream side, holds valid and ctrl until xfer
  modport src (
    output valid,
    output ctrl,
    input  ready,
    input  xfer
  );

  // Downstream side
  modport dst (
    input  valid,
    input  ctrl,
    output ready,
    input  xfer
  );

endinterface

/* rtl/decodeStage.sv */
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module decodeStage (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        instrValid,
  input  logic [`ARM_INSTR_W-1:0]     instr,
  input  logic [`ARM_FLAGS_W-1:0]     aluFlags,
  input  logic [`ARM_ADDR_LOW_W-1:0]  addrLow,
  output logic                        instrReady,
  stageIf.src                         outStage
);
  import armCtrlPkg::*;

  logic       validQ;       // Slot occupied
  ctrlWord_t  ctrlQ;
  ctrlWord_t  ctrlNext;
  logic [2:0] instrClass;
  aluOp_t     opcode;
  logic       isCompare;    // TST/TEQ/CMP/CMN, flags only

  // ====================================================================
  // Instruction decode
  // ====================================================================
  assign instrClass = instr[`ARM_CLASS_MSB:`ARM_CLASS_LSB];
  assign opcode     = aluOp_t'(instr[`ARM_OPC_MSB:`ARM_OPC_LSB]);
  assign isCompare  = opcode inside {aluTst, aluTeq, aluCmp, aluCmn};

  always_comb begin
    ctrlNext          = '0;                     // Every write off by default
    ctrlNext.op       = opUndef;
    ctrlNext.aluOp    = aluAdd;                 // Address / target adder
    ctrlNext.cond     = condCode_t'(instr[`ARM_COND_MSB:`ARM_COND_LSB]);
    ctrlNext.rd       = instr[`ARM_RD_MSB:`ARM_RD_LSB];
    ctrlNext.aluFlags = aluFlags;
    ctrlNext.addrLow  = addrLow;
    case (instrClass)
      3'b000, 3'b001: begin                     // Data processing, reg or imm
        ctrlNext.op       = opDataProc;
        ctrlNext.aluOp    = opcode;
        ctrlNext.regWrite = !isCompare;         // Compares never write Rd
        ctrlNext.setFlags = instr[`ARM_S_BIT];
      end
      3'b010, 3'b011: begin                     // LDR/STR, imm or reg offset
        // Register form with bit 4 set is the undefined space
        if (!(instr[`ARM_I_BIT] && instr[`ARM_REGSHIFT_BIT])) begin
          ctrlNext.op         = instr[`ARM_L_BIT] ? opLoad : opStore;
          ctrlNext.regWrite   = instr[`ARM_L_BIT];
          ctrlNext.memToReg   = instr[`ARM_L_BIT];
          ctrlNext.memWrite   = !instr[`ARM_L_BIT];
          ctrlNext.byteAccess = instr[`ARM_B_BIT];
        end
      end
      3'b101:  ctrlNext.op = opBranch;          // B
      default: ;                                // LDM/STM, coproc, SWI stay undefined
    endcase
  end

  // ====================================================================
  // Decode slot
  // ====================================================================
  assign instrReady = !validQ || outStage.ready;   // Empty or draining

  always_ff @(posedge clk) begin
    if (rst) begin
      validQ <= 1'b0;
    end else if (instrReady) begin
      validQ <= instrValid;
    end
  end

  always_ff @(posedge clk) begin
    if (instrValid && instrReady) begin
      ctrlQ <= ctrlNext;
    end
  end

  assign outStage.valid = validQ;
  assign outStage.ctrl  = ctrlQ;

  // A stalled item must not change under the consumer
  holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
    outStage.valid && !outStage.xfer |=> outStage.valid && $stable(outStage.ctrl));

endmodule

/* rtl/executeStage.sv */
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module executeStage (
  input  logic                     clk,
  input  logic                     rst,
  stageIf.dst                      inStage,
  stageIf.src                      outStage,
  input  logic                     fwdValid,    // Flags pending further down
  input  logic [`ARM_FLAGS_W-1:0]  fwdFlags,
  input  logic [`ARM_FLAGS_W-1:0]  archFlags    // Committed NZCV
);
  import armCtrlPkg::*;

  logic                     validQ;
  ctrlWord_t                ctrlQ;
  ctrlWord_t                ctrlNext;
  logic [`ARM_FLAGS_W-1:0]  curFlags;           // Flags seen by this instruction
  logic                     condPass;
  logic                     isLogical;

  // ARM condition table
  function automatic logic condHolds(input condCode_t cond,
                                     input logic [`ARM_FLAGS_W-1:0] f);
    logic n;
    logic z;
    logic c;
    logic v;
    n = f[`ARM_N_BIT];
    z = f[`ARM_Z_BIT];
    c = f[`ARM_C_BIT];
    v = f[`ARM_V_BIT];
    case (cond)
      condEQ:  return z;
      condNE:  return !z;
      condCS:  return c;
      condCC:  return !c;
      condMI:  return n;
      condPL:  return !n;
      condVS:  return v;
      condVC:  return !v;
      condHI:  return c && !z;
      condLS:  return !c || z;
      condGE:  return n == v;
      condLT:  return n != v;
      condGT:  return !z && (n == v);
      condLE:  return z || (n != v);
      condAL:  return 1'b1;
      default: return 1'b0;                     // NV never executes
    endcase
  endfunction

  // ====================================================================
  // Condition check and next flags
  // ====================================================================
  assign curFlags  = fwdValid ? fwdFlags : archFlags;
  assign condPass  = condHolds(inStage.ctrl.cond, curFlags);
  assign isLogical = inStage.ctrl.aluOp inside
                     {aluAnd, aluEor, aluTst, aluTeq, aluOrr, aluMov, aluBic, aluMvn};

  always_comb begin
    ctrlNext           = inStage.ctrl;
    ctrlNext.condPass  = condPass;
    ctrlNext.flagsNext = curFlags;              // Unchanged unless S and passed
    if (inStage.ctrl.setFlags && condPass) begin
      if (isLogical) begin                      // C and V kept, no shifter carry here
        ctrlNext.flagsNext[`ARM_N_BIT] = inStage.ctrl.aluFlags[`ARM_N_BIT];
        ctrlNext.flagsNext[`ARM_Z_BIT] = inStage.ctrl.aluFlags[`ARM_Z_BIT];
      end else begin
        ctrlNext.flagsNext = inStage.ctrl.aluFlags;
      end
    end
    ctrlNext.regWrite = inStage.ctrl.regWrite && condPass;
    ctrlNext.memWrite = inStage.ctrl.memWrite && condPass;
  end

  // ====================================================================
  // Execute slot
  // ====================================================================
  assign inStage.ready = !validQ || outStage.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      validQ <= 1'b0;
    end else if (inStage.ready) begin
      validQ <= inStage.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (inStage.xfer) begin
      ctrlQ <= ctrlNext;
    end
  end

  assign outStage.valid = validQ;
  assign outStage.ctrl  = ctrlQ;

endmodule

/* rtl/memoryStage.sv */
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module memoryStage (
  input  logic                     clk,
  input  logic                     rst,
  stageIf.dst                      inStage,
  stageIf.src                      outStage,
  output logic                     fwdValid,
  output logic [`ARM_FLAGS_W-1:0]  fwdFlags
);
  import armCtrlPkg::*;

  logic                    validQ;
  ctrlWord_t               ctrlQ;
  ctrlWord_t               ctrlNext;
  logic                    isMemOp;
  logic                    inPending;     // Item leaving execute sets flags
  logic                    slotPending;   // Item held here sets flags

  // Byte lanes for the access
  assign isMemOp = (inStage.ctrl.op == opLoad) || (inStage.ctrl.op == opStore);

  always_comb begin
    ctrlNext          = inStage.ctrl;
    ctrlNext.byteMask = '0;                     // Failed or non-memory ops
    if (isMemOp && inStage.ctrl.condPass) begin
      if (inStage.ctrl.byteAccess) begin
        ctrlNext.byteMask[inStage.ctrl.addrLow] = 1'b1;
      end else begin
        ctrlNext.byteMask = '1;                 // Full word
      end
    end
  end

  // Youngest pending flags win, older ones already sit in their flagsNext
  assign inPending   = inStage.valid && inStage.ctrl.setFlags && inStage.ctrl.condPass;
  assign slotPending = validQ && ctrlQ.setFlags && ctrlQ.condPass;
  assign fwdValid    = inPending || slotPending;
  assign fwdFlags    = inPending ? inStage.ctrl.flagsNext : ctrlQ.flagsNext;

  assign inStage.ready = !validQ || outStage.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      validQ <= 1'b0;
    end else if (inStage.ready) begin
      validQ <= inStage.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (inStage.xfer) ctrlQ <= ctrlNext;       // Payload only, no reset
  end

  assign outStage.valid = validQ;
  assign outStage.ctrl  = ctrlQ;

  // A live lane means the access really happens
  laneImpliesAccess: assert property (@(posedge clk) disable iff (rst)
    outStage.valid && (|outStage.ctrl.byteMask)
      |-> outStage.ctrl.regWrite || outStage.ctrl.memWrite);

endmodule

/* rtl/writebackStage.sv */
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module writebackStage (
  input  logic                     clk,
  input  logic                     rst,
  stageIf.dst                      inStage,
  input  logic                     resReady,
  output logic                     resValid,
  output logic                     resRegWrite,
  output logic                     resMemWrite,
  output logic                     resMemToReg,
  output logic                     resBranchTaken,
  output logic [`ARM_MASK_W-1:0]   resByteMask,
  output logic [`ARM_REG_W-1:0]    resRd,
  output logic [`ARM_FLAGS_W-1:0]  resFlags,
  output logic [`ARM_FLAGS_W-1:0]  archFlags
);
  import armCtrlPkg::*;

  logic                     validQ;
  ctrlWord_t                ctrlQ;
  logic [`ARM_FLAGS_W-1:0]  flagsQ;   // Architectural NZCV

  // ====================================================================
  // Flag register, updated as a flag-setting item enters
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      flagsQ <= '0;
    end else if (inStage.xfer && inStage.ctrl.setFlags && inStage.ctrl.condPass) begin
      flagsQ <= inStage.ctrl.flagsNext;
    end
  end

  assign archFlags = flagsQ;          // Back to execute

  // Output slot
  assign inStage.ready = !validQ || resReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      validQ <= 1'b0;
    end else if (inStage.ready) begin
      validQ <= inStage.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (inStage.xfer) begin
      ctrlQ <= inStage.ctrl;
    end
  end

  assign resValid       = validQ;
  assign resRegWrite    = ctrlQ.regWrite;
  assign resMemWrite    = ctrlQ.memWrite;
  assign resMemToReg    = ctrlQ.memToReg;
  assign resBranchTaken = (ctrlQ.op == opBranch) && ctrlQ.condPass;
  assign resByteMask    = ctrlQ.byteMask;
  assign resRd          = ctrlQ.rd;
  assign resFlags       = ctrlQ.flagsNext;   // NZCV after this item

  // Stores and register writes are exclusive from decode on
  noDualWrite: assert property (@(posedge clk) disable iff (rst)
    resValid |-> !(resRegWrite && resMemWrite));

endmodule

/* rtl/armCtrl.sv */
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module armCtrl (
  input  logic                        clk,
  input  logic                        rst,
  // Instruction side
  input  logic                        instrValid,
  input  logic [`ARM_INSTR_W-1:0]     instr,
  input  logic [`ARM_FLAGS_W-1:0]     aluFlags,   // Datapath NZCV for this instruction
  input  logic [`ARM_ADDR_LOW_W-1:0]  addrLow,
  output logic                        instrReady,
  // Result side
  input  logic                        resReady,
  output logic                        resValid,
  output logic                        resRegWrite,
  output logic                        resMemWrite,
  output logic                        resMemToReg,
  output logic                        resBranchTaken,
  output logic [`ARM_MASK_W-1:0]      resByteMask,
  output logic [`ARM_REG_W-1:0]       resRd,
  output logic [`ARM_FLAGS_W-1:0]     resFlags
);

  logic                     fwdValid;
  logic [`ARM_FLAGS_W-1:0]  fwdFlags;
  logic [`ARM_FLAGS_W-1:0]  archFlags;

  stageIf decToExe ();
  stageIf exeToMem ();
  stageIf memToWb ();

  // ====================================================================
  // Four stages, one slot each
  // ====================================================================
  decodeStage u_decode (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .instr      (instr),
    .aluFlags   (aluFlags),
    .addrLow    (addrLow),
    .instrReady (instrReady),
    .outStage   (decToExe)
  );

  executeStage u_execute (
    .clk       (clk),
    .rst       (rst),
    .inStage   (decToExe),
    .outStage  (exeToMem),
    .fwdValid  (fwdValid),
    .fwdFlags  (fwdFlags),
    .archFlags (archFlags)
  );

  memoryStage u_memory (
    .clk      (clk),
    .rst      (rst),
    .inStage  (exeToMem),
    .outStage (memToWb),
    .fwdValid (fwdValid),    // Pending flags back to execute
    .fwdFlags (fwdFlags)
  );

  writebackStage u_writeback (
    .clk            (clk),
    .rst            (rst),
    .inStage        (memToWb),
    .resReady       (resReady),
    .resValid       (resValid),
    .resRegWrite    (resRegWrite),
    .resMemWrite    (resMemWrite),
    .resMemToReg    (resMemToReg),
    .resBranchTaken (resBranchTaken),
    .resByteMask    (resByteMask),
    .resRd          (resRd),
    .resFlags       (resFlags),
    .archFlags      (archFlags)
  );

endmodule

/* verif/armCtrlTb.sv */
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module armCtrlTb;

  localparam int numInstr       = 400;
  localparam int highPhase      = numInstr / 3;        // resReady held high this long
  localparam int watchdogCycles = numInstr * 4 * 10;

  localparam logic [2:0] kindDp     = 3'd0;
  localparam logic [2:0] kindLoad   = 3'd1;
  localparam logic [2:0] kindStore  = 3'd2;
  localparam logic [2:0] kindBranch = 3'd3;
  localparam logic [2:0] kindUndef  = 3'd4;

  // One predicted result, pushed at acceptance
  typedef struct packed {
    logic [2:0]  kind;
    logic        regWrite;
    logic        memWrite;
    logic        memToReg;
    logic        branchTaken;
    logic [3:0]  byteMask;
    logic [3:0]  rd;
    logic [3:0]  flags;
    logic [31:0] acceptCycle;
  } expResult_t;

  logic                        clk = 1'b0;
  logic                        rst;
  logic                        instrValid;
  logic [`ARM_INSTR_W-1:0]     instr;
  logic [`ARM_FLAGS_W-1:0]     aluFlags;
  logic [`ARM_ADDR_LOW_W-1:0]  addrLow;
  logic                        instrReady;
  logic                        resReady;
  logic                        resValid;
  logic                        resRegWrite;
  logic                        resMemWrite;
  logic                        resMemToReg;
  logic                        resBranchTaken;
  logic [`ARM_MASK_W-1:0]      resByteMask;
  logic [`ARM_REG_W-1:0]       resRd;
  logic [`ARM_FLAGS_W-1:0]     resFlags;

  logic [31:0]  lfsrState = 32'h92c44ca8;
  logic [3:0]   modelFlags = 4'b0000;     // Model NZCV, starts clear
  expResult_t   expQ [$];
  logic [31:0]  cycle = '0;
  logic [31:0]  lastLowCycle = '0;        // Last cycle with resReady low
  logic         holdInstr = 1'b0;
  logic [31:0]  lastSetCycle = '0;        // Accept cycle of the last passing flag setter
  int           acceptCount = 0;
  int           resultCount = 0;
  int           drainCycles = 0;
  int           latencyChecks = 0;
  int           fwdPairs = 0;             // Back-to-back flag setters
  int           kindCount [0:7];
  string        missing = "";

  always #2 clk = ~clk;                   // 4 ns period

  armCtrl u_armCtrl (
    .clk(clk), .rst(rst),
    .instrValid(instrValid), .instr(instr), .aluFlags(aluFlags), .addrLow(addrLow),
    .instrReady(instrReady),
    .resReady(resReady), .resValid(resValid),
    .resRegWrite(resRegWrite), .resMemWrite(resMemWrite), .resMemToReg(resMemToReg),
    .resBranchTaken(resBranchTaken), .resByteMask(resByteMask),
    .resRd(resRd), .resFlags(resFlags)
  );

  // ====================================================================
  // Random source, x^32 + x^22 + x^2 + x + 1
  // ====================================================================
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};  // One step per bit
      val       = {val[30:0], fb};
    end
    return val;
  endfunction

  // Weighted class pick, rest of the word random
  function automatic logic [31:0] randomInstr();
    logic [31:0] w;
    logic [3:0]  pick;
    w    = takeBits(32);
    pick = 4'(takeBits(4));
    if (takeBits(2) == 0) w[`ARM_COND_MSB:`ARM_COND_LSB] = 4'b1110;   // Extra AL
    if (pick < 4'd7) begin
      w[27:26] = 2'b00;                   // Data processing, I bit random
    end else if (pick < 4'd11) begin
      w[27:26] = 2'b01;                   // LDR/STR
      w[4]     = 1'b0;
    end else if (pick < 4'd14) begin
      w[27:25] = 3'b101;                  // B
    end else begin
      case (2'(takeBits(2)))              // Undefined spaces
        2'd0:    w[27:25] = 3'b100;
        2'd1:    w[27:25] = 3'b110;
        2'd2:    w[27:25] = 3'b111;
        default: begin
          w[27:25] = 3'b011;
          w[4]     = 1'b1;
        end
      endcase
    end
    return w;
  endfunction

  // ====================================================================
  // Reference model
  // ====================================================================
  function automatic logic condMet(input logic [3:0] cond, input logic [3:0] f);
    logic base;
    case (cond[3:1])                      // Odd codes are the inverse
      3'd0:    base = f[2];
      3'd1:    base = f[1];
      3'd2:    base = f[3];
      3'd3:    base = f[0];
      3'd4:    base = f[1] && !f[2];
      3'd5:    base = f[3] == f[0];
      3'd6:    base = !f[2] && (f[3] == f[0]);
      default: base = 1'b1;               // AL, NV comes out false
    endcase
    return cond[0] ? !base : base;
  endfunction

  function automatic expResult_t predict(input logic [31:0] w, input logic [3:0] af,
                                         input logic [1:0] al);
    expResult_t e;
    logic [2:0] cls;
    logic [3:0] opc;
    logic       pass;
    logic       isArith;
    e    = '0;
    cls  = w[27:25];
    opc  = w[24:21];
    pass = condMet(w[31:28], modelFlags);
    e.rd   = w[15:12];
    e.kind = kindUndef;
    if (cls == 3'b000 || cls == 3'b001) e.kind = kindDp;
    else if ((cls == 3'b010 || cls == 3'b011) && !(w[25] && w[4]))
      e.kind = w[20] ? kindLoad : kindStore;
    else if (cls == 3'b101) e.kind = kindBranch;
    case (e.kind)
      kindDp: begin
        isArith    = (opc >= 4'd2 && opc <= 4'd7) || opc == 4'd10 || opc == 4'd11;
        e.regWrite = pass && (opc[3:2] != 2'b10);   // TST..CMN write nothing
        if (pass && w[20]) begin
          if (isArith) modelFlags = af;
          else modelFlags[3:2] = af[3:2];           // N and Z only
        end
      end
      kindLoad, kindStore: begin
        e.regWrite = pass && (e.kind == kindLoad);
        e.memWrite = pass && (e.kind == kindStore);
        e.memToReg = (e.kind == kindLoad);
        if (pass) e.byteMask = w[22] ? (4'b0001 << al) : 4'b1111;
      end
      kindBranch: e.branchTaken = pass;
      default: ;
    endcase
    e.flags = modelFlags;
    return e;
  endfunction

  function automatic string kindName(input logic [2:0] k);
    case (k)
      kindDp:     return "dataProc";
      kindLoad:   return "load";
      kindStore:  return "store";
      kindBranch: return "branch";
      default:    return "undef";
    endcase
  endfunction

  // ====================================================================
  // Checking
  // ====================================================================
  task automatic abortRun();
    $display("** FAIL **");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic checkField(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
      abortRun();
    end
  endtask

  task automatic compareResult(input expResult_t e, input int idx);
    string tag;
    tag = $sformatf("%s #%0d", kindName(e.kind), idx);
    checkField({tag, " regWrite"},    32'(e.regWrite),    32'(resRegWrite));
    checkField({tag, " memWrite"},    32'(e.memWrite),    32'(resMemWrite));
    checkField({tag, " memToReg"},    32'(e.memToReg),    32'(resMemToReg));
    checkField({tag, " branchTaken"}, 32'(e.branchTaken), 32'(resBranchTaken));
    checkField({tag, " byteMask"},    32'(e.byteMask),    32'(resByteMask));
    checkField({tag, " rd"},          32'(e.rd),          32'(resRd));
    checkField({tag, " flags"},       32'(e.flags),       32'(resFlags));
    if (lastLowCycle <= e.acceptCycle) begin        // Clear path, fixed latency
      checkField({tag, " latency"}, 32'd4, cycle - e.acceptCycle);
      latencyChecks++;
    end
  endtask

  // New stimulus unless a stalled instruction must be held
  task automatic driveInputs();
    if (!holdInstr) begin
      if (acceptCount < numInstr && takeBits(2) != 0) begin
        instrValid = 1'b1;
        instr      = randomInstr();
        aluFlags   = 4'(takeBits(4));
        addrLow    = 2'(takeBits(2));
      end else begin
        instrValid = 1'b0;
      end
    end
    if (acceptCount < highPhase) resReady = 1'b1;
    else resReady = takeBits(2) != 0;               // Low one cycle in four
  endtask

  // Transfers that happen on the coming edge
  task automatic sampleOutputs();
    expResult_t e;
    logic       setPass;
    if (!resReady) lastLowCycle = cycle;
    if (resValid) begin
      if (expQ.size() == 0) begin
        $display("ERROR: result came out with no instruction in flight, cycle %0d", cycle);
        abortRun();
      end else if (resReady) begin
        e = expQ.pop_front();
        compareResult(e, resultCount);
        resultCount++;
      end
    end
    if (instrValid && instrReady) begin
      // Flag setter that will really change NZCV
      setPass       = (instr[27:26] == 2'b00) && instr[`ARM_S_BIT] &&
                      condMet(instr[31:28], modelFlags);
      e             = predict(instr, aluFlags, addrLow);
      e.acceptCycle = cycle;
      if (setPass && lastSetCycle != 0 && cycle - lastSetCycle <= 2) fwdPairs++;
      if (setPass) lastSetCycle = cycle;              // Still in execute or memory 2 cycles on
      expQ.push_back(e);
      kindCount[e.kind]++;
      acceptCount++;
    end
    holdInstr = instrValid && !instrReady;
    if (resultCount >= numInstr) drainCycles++;
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial begin
    rst        = 1'b1;
    instrValid = 1'b0;
    instr      = '0;
    aluFlags   = '0;
    addrLow    = '0;
    resReady   = 1'b1;
    for (int k = 0; k < 8; k++) kindCount[k] = 0;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    #2;
    checkField("reset resValid",   32'd0, 32'(resValid));
    checkField("reset instrReady", 32'd1, 32'(instrReady));
    while (resultCount < numInstr || drainCycles < 8) begin   // Drain also catches extras
      @(posedge clk);
      cycle++;
      #1 driveInputs();
      #2 sampleOutputs();
    end
    for (int k = 0; k < 5; k++) if (kindCount[k] == 0) missing = kindName(3'(k));
    if (missing != "") begin
      $display("ERROR: no %s instruction was issued", missing);
      abortRun();
    end else if (fwdPairs == 0) begin
      $display("ERROR: no back-to-back flag setters, forwarding was never exercised");
      abortRun();
    end else begin
      $display("%0d results checked, %0d latency checks, %0d forwarding pairs",
               resultCount, latencyChecks, fwdPairs);
      $display("** PASS **");
      $finish;
    end
  end

  // Watchdog sized from the instruction count
  initial begin
    repeat (watchdogCycles) @(posedge clk);
    $display("ERROR: timeout, %0d of %0d results after %0d cycles",
             resultCount, numInstr, watchdogCycles);
    abortRun();
  end

endmodule

/* flist.f */
+incdir+rtl
rtl/armCtrlPkg.sv
rtl/stageIf.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/writebackStage.sv
rtl/armCtrl.sv
verif/armCtrlTb.sv

/* run.sh */
#!/bin/sh
# Build and run the armCtrl testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module armCtrlTb \
  -f flist.f -o simArmCtrl
if [ $? -ne 0 ]; then
  echo "run.sh: compile failed"
  exit 1
fi

./obj_dir/simArmCtrl > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q '\*\* FAIL \*\*' "$LOG"; then
  echo "run.sh: testbench reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "run.sh: simulation exited with status $status"
  exit 1
fi
if ! grep -q '\*\* PASS \*\*' "$LOG"; then
  echo "run.sh: simulation ended without a result line"
  exit 1
fi
exit 0
